// File: Makefile
TOP := tb_rv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f sources.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --top-module rv_core verilog/rv_pkg.sv verilog/alu.sv \
		verilog/reg_file.sv verilog/instr_decoder.sv verilog/uc.sv verilog/fd.sv \
		verilog/rv_core.sv

clean:
	rm -rf obj_dir

// File: sources.f
+incdir+tb
verilog/rv_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/instr_decoder.sv
verilog/uc.sv
verilog/fd.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

// File: tb/tb_program.svh
// program, data preload and expected stores for tb_rv_core

localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;  // pads the unused rom

// operands at doublewords 0..3
localparam logic [XLEN-1:0] OPND_MAX  = 64'h7fff_ffff_ffff_ffff;
localparam logic [XLEN-1:0] OPND_ONE  = 64'h0000_0000_0000_0001;
localparam logic [XLEN-1:0] OPND_NEG  = 64'hffff_ffff_ffff_fff0;  // -16
localparam logic [XLEN-1:0] OPND_LOAD = 64'h0123_4567_89ab_cdef;
localparam logic [XLEN-1:0] DATA_INIT [4] = '{OPND_MAX, OPND_ONE, OPND_NEG, OPND_LOAD};

localparam int N_PROG    = 29;
localparam int HALT_WORD = 28;  // ebreak at byte 108 still advances the pc once

localparam logic [31:0] PROG [N_PROG] = '{
    32'h0000_3083,  // 0    ld   x1, 0(x0)
    32'h0080_3103,  // 4    ld   x2, 8(x0)
    32'h0100_3183,  // 8    ld   x3, 16(x0)
    32'h0020_8233,  // 12   add  x4, x1, x2
    32'h0840_3023,  // 16   sd   x4, 128(x0)
    32'h4031_02b3,  // 20   sub  x5, x2, x3
    32'h0850_3423,  // 24   sd   x5, 136(x0)
    32'h0030_f333,  // 28   and  x6, x1, x3
    32'h0860_3823,  // 32   sd   x6, 144(x0)
    32'h0031_63b3,  // 36   or   x7, x2, x3
    32'h0870_3c23,  // 40   sd   x7, 152(x0)
    32'h0021_a433,  // 44   slt  x8, x3, x2
    32'h0a80_3023,  // 48   sd   x8, 160(x0)
    32'h0031_24b3,  // 52   slt  x9, x2, x3
    32'h0a90_3423,  // 56   sd   x9, 168(x0)
    32'hffb0_0513,  // 60   addi x10, x0, -5
    32'h0aa0_3823,  // 64   sd   x10, 176(x0)
    32'h0071_0013,  // 68   addi x0, x2, 7
    32'h0a00_3c23,  // 72   sd   x0, 184(x0)
    32'h0180_3583,  // 76   ld   x11, 24(x0)
    32'h0015_8593,  // 80   addi x11, x11, 1
    32'h0400_0613,  // 84   addi x12, x0, 64
    32'h08b6_3423,  // 88   sd   x11, 136(x12)
    32'h0021_0463,  // 92   beq  x2, x2, +8
    32'h0c10_3823,  // 96   sd   x1, 208(x0)   skipped
    32'h0031_0463,  // 100  beq  x2, x3, +8
    32'h0c20_3c23,  // 104  sd   x2, 216(x0)
    32'h0010_0073,  // 108  ebreak
    32'h0e10_3023   // 112  sd   x1, 224(x0)   fetched while halted, never stored
};

typedef struct packed {
    logic [DMEM_ADDR_W-1:0] idx;   // doubleword index
    logic [XLEN-1:0]        data;
} store_t;

localparam int N_STORES = 10;
localparam store_t EXP_STORES [N_STORES] = '{
    '{6'(128 / 8), OPND_MAX + OPND_ONE},  // wraps into the sign bit
    '{6'(136 / 8), OPND_ONE - OPND_NEG},
    '{6'(144 / 8), OPND_MAX & OPND_NEG},
    '{6'(152 / 8), OPND_ONE | OPND_NEG},
    '{6'(160 / 8), {63'd0, $signed(OPND_NEG) < $signed(OPND_ONE)}},
    '{6'(168 / 8), {63'd0, $signed(OPND_ONE) < $signed(OPND_NEG)}},
    '{6'(176 / 8), -64'sd5},              // upper half all ones
    '{6'(184 / 8), 64'd0},                // x0 ignores the addi
    '{6'((64 + 136) / 8), OPND_LOAD + 64'd1},
    '{6'(216 / 8), OPND_ONE}              // after the not-taken beq
};

// alu flags {zero, neg, carry, ovf} expected while a word executes
typedef struct packed {
    logic [IMEM_ADDR_W-1:0] word;   // instruction word index
    alu_flags_t             flags;
} flag_chk_t;

localparam int N_FLAG_CHECKS = 4;
localparam flag_chk_t EXP_FLAGS [N_FLAG_CHECKS] = '{
    '{6'(12 / 4), 4'b0101},   // max + 1 overflows into the sign bit without carry out
    '{6'(60 / 4), 4'b0100},   // 0 + (-5) is negative
    '{6'(92 / 4), 4'b1010},   // equal operands give zero and no borrow
    '{6'(100 / 4), 4'b0000}   // unsigned 1 is below -16 so it borrows
};

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    import rv_pkg::*;

    localparam int IMEM_ADDR_W  = 6;
    localparam int DMEM_ADDR_W  = 6;
    localparam int CLK_PERIOD   = 40;   // ns
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 100;  // cycles per wait
    localparam int QUIET_CYCLES = 10;   // watched after halt

    `include "tb_program.svh"

    logic                   clk;
    logic                   arst_n;
    logic [IMEM_ADDR_W-1:0] i_mem_addr;
    logic [31:0]            i_mem_data;
    logic [DMEM_ADDR_W-1:0] d_mem_addr;
    logic [XLEN-1:0]        d_mem_wdata;
    logic [XLEN-1:0]        d_mem_rdata;
    logic                   d_mem_we;
    alu_flags_t             alu_flags;
    logic                   halted;

    logic [31:0]     imem [0:(1<<IMEM_ADDR_W)-1];
    logic [XLEN-1:0] dmem [0:(1<<DMEM_ADDR_W)-1];
    store_t          store_log [$];  // stores seen in order

    int     errors;
    int     timeouts;
    int     checks;
    int     flag_hits;  // flag table entries visited
    bit     ok;
    store_t got;

    rv_core #(
        .IMEM_ADDR_W (IMEM_ADDR_W),
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) rv_core_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .i_mem_addr  (i_mem_addr),
        .i_mem_data  (i_mem_data),
        .d_mem_addr  (d_mem_addr),
        .d_mem_wdata (d_mem_wdata),
        .d_mem_rdata (d_mem_rdata),
        .d_mem_we    (d_mem_we),
        .alu_flags   (alu_flags),
        .halted      (halted)
    );

    // zero-latency memories
    assign i_mem_data  = imem[i_mem_addr];
    assign d_mem_rdata = dmem[d_mem_addr];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // preload word built from the whole doubleword index
    function automatic logic [XLEN-1:0] fill_word(input int a);
        if (a < 4) begin
            return DATA_INIT[a];
        end
        return {16'hda7a, 16'(a), ~32'(a)};
    endfunction

    // data ram reloads its image during reset and logs every store
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int a = 0; a < (1 << DMEM_ADDR_W); a++) begin
                dmem[a] <= fill_word(a);
            end
        end else if (d_mem_we) begin
            dmem[d_mem_addr] <= d_mem_wdata;
            store_log.push_back({d_mem_addr, d_mem_wdata});
        end
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] got_v,
                               input logic [XLEN-1:0] exp_v);
        checks++;
        if (got_v !== exp_v) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got_v, exp_v);
        end
    endtask

    // alu flags on the words listed in the flag table
    always @(negedge clk) begin
        if (arst_n && !halted) begin
            for (int k = 0; k < N_FLAG_CHECKS; k++) begin
                if (i_mem_addr == EXP_FLAGS[k].word) begin
                    flag_hits++;
                    check_value($sformatf("alu_flags (word %0d)", EXP_FLAGS[k].word),
                                alu_flags, EXP_FLAGS[k].flags);
                end
            end
        end
    end

    task automatic check_reset_outputs();
        check_value("i_mem_addr", i_mem_addr, 0);
        check_value("d_mem_we", d_mem_we, 0);
        check_value("halted", halted, 0);
    endtask

    // polls the store log at each falling edge
    task automatic wait_for_store(output store_t s, output bit found);
        int cyc;
        found = 1'b0;
        s     = '0;
        cyc   = 0;
        while (!found && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            if (store_log.size() > 0) begin
                s     = store_log.pop_front();
                found = 1'b1;
            end
            cyc++;
        end
    endtask

    task automatic wait_for_halt(output bit found);
        int cyc;
        found = 1'b0;
        cyc   = 0;
        while (!found && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            found = halted;
            cyc++;
        end
    endtask

    // core must sit still once halted
    task automatic confirm_quiet();
        logic [IMEM_ADDR_W-1:0] held;
        held = i_mem_addr;
        check_value("i_mem_addr", i_mem_addr, HALT_WORD);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("i_mem_addr", i_mem_addr, held);
            check_value("d_mem_we", d_mem_we, 0);
            check_value("halted", halted, 1);
        end
        if (store_log.size() != 0) begin
            errors++;
            $display("store seen after halt, %0d extra store(s) logged", store_log.size());
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        errors    = 0;
        timeouts  = 0;
        checks    = 0;
        flag_hits = 0;
        ok        = 1'b1;
        for (int w = 0; w < (1 << IMEM_ADDR_W); w++) begin
            if (w < N_PROG) begin
                imem[w] = PROG[w];
            end else begin
                imem[w] = EBREAK_WORD;
            end
        end

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_reset_outputs();  // first fetch still at pc 0

        // expected stores in program order
        for (int n = 0; n < N_STORES; n++) begin
            if (ok) begin
                wait_for_store(got, ok);
                if (ok) begin
                    check_value($sformatf("d_mem_addr (store %0d)", n), got.idx,
                                EXP_STORES[n].idx);
                    check_value($sformatf("d_mem_wdata (store %0d)", n), got.data,
                                EXP_STORES[n].data);
                end else begin
                    timeouts++;
                    $display("timeout: store %0d did not appear within %0d cycles",
                             n, WAIT_LIMIT);
                end
            end
        end

        if (ok) begin
            wait_for_halt(ok);
            if (!ok) begin
                timeouts++;
                $display("timeout: halted never went high after the last store");
            end
        end
        if (ok) begin
            confirm_quiet();
            check_value("flag checks seen", flag_hits, N_FLAG_CHECKS);
        end

        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic [rv_pkg::XLEN-1:0]  a,
    input  wire logic [rv_pkg::XLEN-1:0]  b,
    input  wire rv_pkg::alu_cmd_e         alu_cmd,
    input  wire logic                     alu_src,  // b is an immediate
    input  wire logic [2:0]               funct3,
    input  wire logic [6:0]               funct7,
    output logic [rv_pkg::XLEN-1:0]       result,
    output rv_pkg::alu_flags_t            flags
);

    import rv_pkg::*;

    alu_op_e         op;
    logic            use_sub;   // adder runs a - b
    logic            arith;     // op goes through the adder
    logic [XLEN-1:0] b_eff;
    logic [XLEN:0]   sum_ext;   // extra bit holds the carry
    logic            ovf_raw;
    logic            lt;        // signed a < b

    // command plus funct fields to operation
    always_comb begin
        case (alu_cmd)
            CMD_ADD: op = ALU_ADD;
            CMD_SUB: op = ALU_SUB;
            CMD_FUNCT: begin
                case (funct3)
                    3'b000:  op = (funct7[5] && !alu_src) ? ALU_SUB : ALU_ADD;  // no subi
                    3'b010:  op = ALU_SLT;
                    3'b110:  op = ALU_OR;
                    3'b111:  op = ALU_AND;
                    default: op = ALU_ADD;
                endcase
            end
            default: op = ALU_ADD;
        endcase
    end

    // one shared adder, subtract as a + ~b + 1
    assign use_sub = (op == ALU_SUB) || (op == ALU_SLT);
    assign arith   = use_sub || (op == ALU_ADD);
    assign b_eff   = use_sub ? ~b : b;
    assign sum_ext = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, use_sub};

    // operands agree in sign but the sum does not
    assign ovf_raw = (a[XLEN-1] == b_eff[XLEN-1]) && (sum_ext[XLEN-1] != a[XLEN-1]);
    assign lt      = sum_ext[XLEN-1] ^ ovf_raw;

    always_comb begin
        case (op)
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lt};
            default: result = sum_ext[XLEN-1:0];  // add and sub
        endcase
    end

    // status flags, carry and ovf only meaningful for adder ops
    assign flags.zero  = (result == '0);
    assign flags.neg   = result[XLEN-1];
    assign flags.carry = arith & sum_ext[XLEN];   // high means no borrow on sub
    assign flags.ovf   = arith & ovf_raw;

endmodule

`default_nettype wire

// File: verilog/fd.sv
`timescale 1ns/1ps
`default_nettype none

module fd #(
    parameter int IMEM_ADDR_W = 6,  // instruction word address bits
    parameter int DMEM_ADDR_W = 6   // doubleword data address bits
) (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire rv_pkg::ctrl_t             ctrl,
    input  wire logic                      halted,
    output rv_pkg::opcode_e                opcode,
    output logic                           ebreak,
    output logic [IMEM_ADDR_W-1:0]         i_mem_addr,
    input  wire logic [31:0]               i_mem_data,
    output logic [DMEM_ADDR_W-1:0]         d_mem_addr,
    output logic [rv_pkg::XLEN-1:0]        d_mem_wdata,
    input  wire logic [rv_pkg::XLEN-1:0]   d_mem_rdata,
    output rv_pkg::alu_flags_t             alu_flags
);

    import rv_pkg::*;

    logic [PC_W-1:0] pc_q;      // program counter
    logic [PC_W-1:0] pc_d;
    logic [PC_W-1:0] pc_plus4;
    logic [PC_W-1:0] pc_target; // branch destination

    logic [4:0]      ra;
    logic [4:0]      rb;
    logic [4:0]      rw;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm;       // already sign extended

    logic [XLEN-1:0] dout_a;
    logic [XLEN-1:0] dout_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;   // register file write data

    // field split and immediate build
    instr_decoder instr_decoder_inst (
        .instr  (i_mem_data),
        .opcode (opcode),
        .ra     (ra),
        .rb     (rb),
        .rw     (rw),
        .funct3 (funct3),
        .funct7 (funct7),
        .imm    (imm)
    );

    // only ebreak has these upper bits on a SYSTEM opcode
    assign ebreak = (i_mem_data[31:7] == EBREAK_FIELDS);

    reg_file reg_file_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ra     (ra),
        .rb     (rb),
        .rw     (rw),
        .we     (ctrl.rf_we),
        .din    (wb_data),
        .dout_a (dout_a),
        .dout_b (dout_b)
    );

    assign alu_b = ctrl.alu_src ? imm : dout_b;  // operand b mux

    alu alu_inst (
        .a       (dout_a),
        .b       (alu_b),
        .alu_cmd (ctrl.alu_cmd),
        .alu_src (ctrl.alu_src),
        .funct3  (funct3),
        .funct7  (funct7),
        .result  (alu_result),
        .flags   (alu_flags)
    );

    // write back select
    assign wb_data = ctrl.rf_src ? d_mem_rdata : alu_result;

    // next pc
    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + imm[PC_W-1:0];

    always_comb begin
        if (halted) begin
            pc_d = pc_q;                     // frozen after ebreak
        end else if (ctrl.pc_src && alu_flags.zero) begin
            pc_d = pc_target;                // beq taken
        end else begin
            pc_d = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;                      // boot from address 0
        end else begin
            pc_q <= pc_d;
        end
    end

    // memory ports
    assign i_mem_addr  = pc_q[IMEM_ADDR_W+1:2];        // word index
    assign d_mem_addr  = alu_result[DMEM_ADDR_W+2:3];  // doubleword index
    assign d_mem_wdata = dout_b;                       // sd stores rs2

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire logic [31:0]          instr,
    output rv_pkg::opcode_e           opcode,
    output logic [4:0]                ra,      // rs1
    output logic [4:0]                rb,      // rs2
    output logic [4:0]                rw,      // rd
    output logic [2:0]                funct3,
    output logic [6:0]                funct7,
    output logic [rv_pkg::XLEN-1:0]   imm
);

    import rv_pkg::*;

    logic [XLEN-1:0] imm_i;  // addi, ld, system
    logic [XLEN-1:0] imm_s;  // sd
    logic [XLEN-1:0] imm_b;  // beq

    // fixed positions in every format
    assign opcode = opcode_e'(instr[6:0]);
    assign rw     = instr[11:7];
    assign funct3 = instr[14:12];
    assign ra     = instr[19:15];
    assign rb     = instr[24:20];
    assign funct7 = instr[31:25];

    // sign bit is always instr[31]
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(XLEN-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};  // lsb always zero

    always_comb begin
        case (opcode)
            OPC_STORE:  imm = imm_s;
            OPC_BRANCH: imm = imm_b;
            default:    imm = imm_i;  // don't care for r-type
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic [4:0]               ra,
    input  wire logic [4:0]               rb,
    input  wire logic [4:0]               rw,
    input  wire logic                     we,
    input  wire logic [rv_pkg::XLEN-1:0]  din,
    output logic [rv_pkg::XLEN-1:0]       dout_a,
    output logic [rv_pkg::XLEN-1:0]       dout_b
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [0:31];

    // write port, x0 never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rw != 5'd0) begin
            regs[rw] <= din;
        end
    end

    // async reads
    assign dout_a = (ra == 5'd0) ? '0 : regs[ra];  // hard zero
    assign dout_b = (rb == 5'd0) ? '0 : regs[rb];

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int IMEM_ADDR_W = 6,  // 64 instruction words
    parameter int DMEM_ADDR_W = 6   // 64 doublewords
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    output logic [IMEM_ADDR_W-1:0]        i_mem_addr,
    input  wire logic [31:0]              i_mem_data,
    output logic [DMEM_ADDR_W-1:0]        d_mem_addr,
    output logic [rv_pkg::XLEN-1:0]       d_mem_wdata,
    input  wire logic [rv_pkg::XLEN-1:0]  d_mem_rdata,
    output logic                          d_mem_we,
    output rv_pkg::alu_flags_t            alu_flags,
    output logic                          halted
);

    import rv_pkg::*;

    opcode_e opcode;   // fd -> uc
    logic    ebreak;   // fd -> uc
    ctrl_t   ctrl;     // uc -> fd

    uc uc_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .opcode (opcode),
        .ebreak (ebreak),
        .ctrl   (ctrl),
        .halted (halted)
    );

    fd #(
        .IMEM_ADDR_W (IMEM_ADDR_W),
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) fd_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl),
        .halted      (halted),
        .opcode      (opcode),
        .ebreak      (ebreak),
        .i_mem_addr  (i_mem_addr),
        .i_mem_data  (i_mem_data),
        .d_mem_addr  (d_mem_addr),
        .d_mem_wdata (d_mem_wdata),
        .d_mem_rdata (d_mem_rdata),
        .alu_flags   (alu_flags)
    );

    assign d_mem_we = ctrl.d_mem_we;  // straight from the control bundle

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // datapath widths
    localparam int XLEN = 64;  // register and data width
    localparam int PC_W = 32;  // program counter width

    // bits 31:7 of ebreak, everything above the opcode
    localparam logic [24:0] EBREAK_FIELDS = 25'h000_2000;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // add sub and or slt
        OPC_OP_IMM = 7'b0010011,  // addi
        OPC_LOAD   = 7'b0000011,  // ld
        OPC_STORE  = 7'b0100011,  // sd
        OPC_BRANCH = 7'b1100011,  // beq
        OPC_SYSTEM = 7'b1110011   // ebreak and friends
    } opcode_e;

    // request from the control unit to the alu
    typedef enum logic [3:0] {
        CMD_ADD   = 4'd0,  // address calculation
        CMD_SUB   = 4'd1,  // compare for beq
        CMD_FUNCT = 4'd2   // let funct3/funct7 decide
    } alu_cmd_e;

    // operation actually carried out by the alu
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4
    } alu_op_e;

    // control unit state
    typedef enum logic {
        ST_RUN  = 1'b0,
        ST_HALT = 1'b1
    } uc_state_e;

    // strobes from uc into the datapath
    typedef struct packed {
        logic     rf_we;     // register file write
        logic     d_mem_we;  // data memory write
        logic     pc_src;    // branch select, taken when zero flag set
        logic     rf_src;    // write back from memory instead of alu
        logic     alu_src;   // alu operand b is the immediate
        alu_cmd_e alu_cmd;
    } ctrl_t;

    // alu status
    typedef struct packed {
        logic zero;   // result is all zeros
        logic neg;    // msb of result
        logic carry;  // carry out, or no borrow on subtract
        logic ovf;    // signed overflow
    } alu_flags_t;

endpackage

`default_nettype wire

// File: verilog/uc.sv
`timescale 1ns/1ps
`default_nettype none

module uc (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire rv_pkg::opcode_e opcode,   // from the instruction word
    input  wire logic           ebreak,   // upper fields match ebreak
    output rv_pkg::ctrl_t       ctrl,
    output logic                halted
);

    import rv_pkg::*;

    uc_state_e state_q;
    uc_state_e state_d;
    ctrl_t     dec;       // raw decode, before halt masking
    logic      brk_req;   // current instruction is ebreak

    // opcode decode
    always_comb begin
        dec     = '0;        // unknown opcodes do nothing
        brk_req = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec.rf_we   = 1'b1;
                dec.alu_cmd = CMD_FUNCT;  // reg-reg, funct picks the op
            end
            OPC_OP_IMM: begin
                dec.rf_we   = 1'b1;
                dec.alu_src = 1'b1;
                dec.alu_cmd = CMD_FUNCT;  // alu masks funct7 when alu_src set
            end
            OPC_LOAD: begin
                dec.rf_we   = 1'b1;
                dec.rf_src  = 1'b1;       // write back memory data
                dec.alu_src = 1'b1;
                dec.alu_cmd = CMD_ADD;    // base + offset
            end
            OPC_STORE: begin
                dec.d_mem_we = 1'b1;
                dec.alu_src  = 1'b1;
                dec.alu_cmd  = CMD_ADD;
            end
            OPC_BRANCH: begin
                dec.pc_src  = 1'b1;
                dec.alu_cmd = CMD_SUB;    // rs1 - rs2, zero means equal
            end
            OPC_SYSTEM: begin
                brk_req = ebreak;         // ecall etc just fall through
            end
            default: ;
        endcase
    end

    // once halted stay there until reset
    assign state_d = (state_q == ST_RUN && brk_req) ? ST_HALT : state_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign halted = (state_q == ST_HALT);

    // kill every side effect while halted
    always_comb begin
        ctrl = dec;
        if (halted) begin
            ctrl.rf_we    = 1'b0;
            ctrl.d_mem_we = 1'b0;
            ctrl.pc_src   = 1'b0;
        end
    end

endmodule

`default_nettype wire
